/* list.f */
+incdir+verilog
verilog/ternary_pkg.sv
verilog/trit_lane_if.sv
verilog/trit_counter.sv
verilog/alu_sequencer.sv
verilog/trit_unit.sv
verilog/word_datapath.sv
verilog/ternary_alu.sv
test/ternary_alu_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the ternary ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f \
    --top-module ternary_alu_tb -o ternary_alu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/ternary_alu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

/* test/ternary_alu_tb.sv */
// Testbench for the trit-serial ternary ALU with a random stimulus and a reference model
`timescale 1ns/100ps
`include "ternary_macros.svh"

module ternary_alu_tb
    import ternary_pkg::*;
;

    localparam int NUM_TRANS    = 400;
    localparam int MAX_STALLS   = 8;
    localparam int CLOCK_PERIOD = 20;
    // Accept and run, worst stall and some margin per transaction
    localparam int WATCHDOG_NS  = NUM_TRANS * (10 + MAX_STALLS + 4) * CLOCK_PERIOD;

    logic                    clock;
    logic                    arst_n;
    logic                    req_valid;
    logic                    req_ready;
    logic [`OPCODE_BITS-1:0] req_opcode;
    logic [`WORD_BITS-1:0]   req_a;
    logic [`WORD_BITS-1:0]   req_b;
    logic                    res_valid;
    logic                    res_ready;
    logic [`WORD_BITS-1:0]   res_data;

    logic [31:0] rng_state;
    int          checks;
    int          errors;
    opcode_t     op_list [19];

    ternary_alu ternary_alu_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_opcode (req_opcode),
        .req_a      (req_a),
        .req_b      (req_b),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // One LCG step
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper LCG bits have the longer period
    function automatic int random_below(input int n);
        return int'((next_random() >> 16) % n);
    endfunction

    function automatic int trit_to_int(input logic [1:0] t);
        case (t)
            2'b11:   return -1;
            2'b01:   return 1;
            default: return 0;
        endcase
    endfunction

    function automatic logic [1:0] int_to_trit(input int v);
        if (v < 0) begin
            return 2'b11;
        end else if (v > 0) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    // Only the three valid codes
    function automatic logic [`WORD_BITS-1:0] random_word();
        logic [`WORD_BITS-1:0] w;
        for (int i = 0; i < `TRITS; i++) begin
            w[2*i +: 2] = int_to_trit(random_below(3) - 1);
        end
        return w;
    endfunction

    function automatic int word_to_int(input logic [`WORD_BITS-1:0] w);
        int acc;
        int weight;
        acc = 0;
        weight = 1;
        for (int i = 0; i < `TRITS; i++) begin
            acc += trit_to_int(w[2*i +: 2]) * weight;
            weight *= 3;
        end
        return acc;
    endfunction

    // Remainder 2 becomes a -1 digit with a borrow upward
    function automatic logic [`WORD_BITS-1:0] int_to_word(input int v);
        logic [`WORD_BITS-1:0] w;
        int val;
        int r;
        val = v;
        for (int i = 0; i < `TRITS; i++) begin
            r = val % 3;
            if (r < 0) begin
                r += 3;
            end
            if (r == 2) begin
                w[2*i +: 2] = int_to_trit(-1);
                val = (val + 1) / 3;
            end else begin
                w[2*i +: 2] = int_to_trit(r);
                val = (val - r) / 3;
            end
        end
        return w;
    endfunction

    // Fold a sum into -9841..9841 modulo 3^9
    function automatic int wrap_word(input int s);
        int v;
        v = s;
        while (v > 9841) begin
            v -= 19683;
        end
        while (v < -9841) begin
            v += 19683;
        end
        return v;
    endfunction

    function automatic int logic_trit(input opcode_t op, input int x, input int y);
        case (op)
            OP_NOT:          return -x;
            OP_AND, OP_ANDI: return (x < y) ? x : y;
            OP_OR:           return (x > y) ? x : y;
            default: begin
                // XOR table
                if (y == 0) begin
                    return x;
                end else if (x == 0) begin
                    return y;
                end else if (x != y) begin
                    return 0;
                end
                return -1;
            end
        endcase
    endfunction

    function automatic logic [`WORD_BITS-1:0] expected_result(input opcode_t op,
            input logic [`WORD_BITS-1:0] a, input logic [`WORD_BITS-1:0] b);
        logic [`WORD_BITS-1:0] w;
        case (op)
            OP_ADD, OP_ADDI: return int_to_word(wrap_word(word_to_int(a) + word_to_int(b)));
            OP_SUB:          return int_to_word(wrap_word(word_to_int(a) - word_to_int(b)));
            // Plus one in trit 0 on a match
            OP_COMP:         return (a == b) ? `WORD_BITS'(1) : `WORD_BITS'(0);
            OP_NOT, OP_AND, OP_ANDI, OP_OR, OP_XOR: begin
                for (int i = 0; i < `TRITS; i++) begin
                    w[2*i +: 2] = int_to_trit(logic_trit(op, trit_to_int(a[2*i +: 2]),
                                                         trit_to_int(b[2*i +: 2])));
                end
                return w;
            end
            default:         return a;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, want);
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("The run timed out before all transactions finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [`WORD_BITS-1:0] a_word;
        logic [`WORD_BITS-1:0] b_word;
        logic [`WORD_BITS-1:0] expected;
        logic [`WORD_BITS-1:0] held;
        opcode_t               op;
        int                    cycles;
        int                    stalls;
        bit                    ready_now;
        bit                    done;
        string                 tag;

        op_list = '{OP_MV, OP_NOT, OP_AND, OP_OR, OP_XOR, OP_ADD, OP_SUB, OP_COMP,
                    OP_ANDI, OP_ADDI, OP_SRI, OP_SLI, OP_LUI, OP_LI, OP_BEQ, OP_BNE,
                    OP_LOAD, OP_STORE, OP_HALT};
        rng_state  = 32'h49881050;
        checks     = 0;
        errors     = 0;
        clock      = 1'b0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_opcode = '0;
        req_a      = '0;
        req_b      = '0;
        res_ready  = 1'b0;

        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_equal(req_ready, 1, "req_ready after reset");
        check_equal(res_valid, 0, "res_valid after reset");

        for (int n = 0; n < NUM_TRANS; n++) begin
            op = op_list[random_below(19)];
            a_word = random_word();
            b_word = random_word();
            // Force some matches so COMP sees both outcomes
            if (op == OP_COMP && random_below(4) == 0) begin
                b_word = a_word;
            end
            expected = expected_result(op, a_word, b_word);
            tag = $sformatf("%s a=%h b=%h", op.name(), a_word, b_word);

            req_valid  = 1'b1;
            req_opcode = op;
            req_a      = a_word;
            req_b      = b_word;
            check_equal(req_ready, 1, {tag, " req_ready before request"});
            @(negedge clock);

            // Scramble the bus while the DUT holds its own operand copy
            req_valid = 1'b0;
            req_a     = random_word();
            req_b     = random_word();
            check_equal(req_ready, 0, {tag, " req_ready during run"});
            // Rising edges since the accepting edge
            cycles = 0;
            while (!res_valid && cycles <= 20) begin
                @(negedge clock);
                cycles++;
            end
            check_equal(cycles, 9, {tag, " cycles from accept to res_valid"});
            check_equal(res_data, expected, {tag, " result"});

            held   = res_data;
            stalls = 0;
            done   = 1'b0;
            while (!done) begin
                ready_now = (stalls >= MAX_STALLS) || (random_below(4) != 0);
                res_ready = ready_now;
                @(negedge clock);
                if (ready_now) begin
                    check_equal(req_ready, 1, {tag, " req_ready after transfer"});
                    check_equal(res_valid, 0, {tag, " res_valid after transfer"});
                    done = 1'b1;
                end else begin
                    check_equal(res_valid, 1, {tag, " res_valid under stall"});
                    check_equal(res_data, held, {tag, " res_data under stall"});
                    check_equal(req_ready, 0, {tag, " req_ready under stall"});
                    stalls++;
                end
            end
            res_ready = 1'b0;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog/alu_sequencer.sv */
// ALU control FSM: request accept, nine-trit run phase, result hand-off
`timescale 1ns/100ps

module alu_sequencer
    import ternary_pkg::*;
(
    input  logic clock,
    input  logic arst_n,
    input  logic req_valid,
    input  logic res_ready,
    input  logic last,
    output logic req_ready,
    output logic res_valid,
    output logic load,
    output logic advance,
    output logic count_clear,
    output logic count_enable
);

    seq_state_t state;
    seq_state_t state_next;

    // Only one operation in flight
    assign req_ready = (state == ST_IDLE);
    assign res_valid = (state == ST_DONE);

    // Capture operands on the accepting edge
    assign load        = req_valid && req_ready;
    assign count_clear = load;

    // One trit per run cycle
    assign advance      = (state == ST_RUN);
    assign count_enable = advance;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (load) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                // Top trit goes through the lane this cycle
                if (last) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                // Hold the result under back-pressure
                if (res_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* verilog/ternary_alu.sv */
// Trit-serial balanced-ternary ALU with valid/ready request and result channels
`timescale 1ns/100ps
`include "ternary_macros.svh"

module ternary_alu
    import ternary_pkg::*;
(
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [`OPCODE_BITS-1:0] req_opcode,
    input  logic [`WORD_BITS-1:0]   req_a,
    input  logic [`WORD_BITS-1:0]   req_b,
    output logic                    res_valid,
    input  logic                    res_ready,
    output logic [`WORD_BITS-1:0]   res_data
);

    logic load;
    logic advance;
    logic count_clear;
    logic count_enable;
    logic last;

    // One trit step per cycle between datapath and trit unit
    trit_lane_if lane_if ();

    alu_sequencer alu_sequencer_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .res_ready    (res_ready),
        .last         (last),
        .req_ready    (req_ready),
        .res_valid    (res_valid),
        .load         (load),
        .advance      (advance),
        .count_clear  (count_clear),
        .count_enable (count_enable)
    );

    trit_counter trit_counter_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .clear  (count_clear),
        .enable (count_enable),
        .last   (last)
    );

    word_datapath word_datapath_inst (
        .clock   (clock),
        .arst_n  (arst_n),
        .load    (load),
        .advance (advance),
        .opcode  (opcode_t'(req_opcode)),
        .a       (req_a),
        .b       (req_b),
        .result  (res_data),
        .lane    (lane_if.lane)
    );

    trit_unit trit_unit_inst (
        .lane (lane_if.unit)
    );

endmodule

/* verilog/ternary_macros.svh */
// Ternary word geometry shared by the ALU datapath, counter and testbench
`ifndef TERNARY_MACROS_SVH
`define TERNARY_MACROS_SVH

// Trits held in one word
`define TRITS 9

// Two-bit trit code, 11 is -1, 00 is 0, 01 is +1
`define TRIT_BITS 2

// Full word width in bits
`define WORD_BITS (`TRITS * `TRIT_BITS)

// Three-trit opcode, two bits per trit
`define OPCODE_BITS 6

// Wide enough for trit positions 0 to 8
`define COUNT_BITS 4

`endif

/* verilog/ternary_pkg.sv */
// Ternary ALU types: trit codes, opcodes and sequencer states
`include "ternary_macros.svh"

package ternary_pkg;

    // Unused code 2'b10 is read as zero by the trit unit
    typedef enum logic [`TRIT_BITS-1:0] {
        TRIT_ZERO = 2'b00,
        TRIT_POS  = 2'b01,
        TRIT_NEG  = 2'b11
    } trit_t;

    // Opcode encodings of the instruction set, three trits each
    typedef enum logic [`OPCODE_BITS-1:0] {
        OP_MV    = 6'b000000,
        OP_NOT   = 6'b000011,
        OP_AND   = 6'b000101,
        OP_OR    = 6'b000111,
        OP_XOR   = 6'b001100,
        OP_ADD   = 6'b001101,
        OP_SUB   = 6'b001111,
        OP_COMP  = 6'b010011,
        OP_ANDI  = 6'b010100,
        OP_ADDI  = 6'b010101,
        OP_SRI   = 6'b010111,
        OP_SLI   = 6'b011100,
        OP_LUI   = 6'b011101,
        OP_LI    = 6'b011111,
        OP_BEQ   = 6'b110000,
        OP_BNE   = 6'b110001,
        OP_LOAD  = 6'b110101,
        OP_STORE = 6'b110111,
        OP_HALT  = 6'b111111
    } opcode_t;

    // Request, trit-serial run, result hand-off
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b10
    } seq_state_t;

endpackage

/* verilog/trit_counter.sv */
// Trit position counter, flags the last trit of the word
`timescale 1ns/100ps
`include "ternary_macros.svh"

module trit_counter (
    input  logic clock,
    input  logic arst_n,
    input  logic clear,
    input  logic enable,
    output logic last
);

    // Position of the trit now in the lane
    logic [`COUNT_BITS-1:0] count;

    // Final position of a word
    assign last = (count == `COUNT_BITS'(`TRITS - 1));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable) begin
            // Wrap after the top trit so the count stays in 0..8
            if (last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* verilog/trit_lane_if.sv */
// Trit lane carrying one trit step between the word datapath and the trit unit
`timescale 1ns/100ps

interface trit_lane_if
    import ternary_pkg::*;
();

    // Operation and operand trits for the current position
    opcode_t opcode;
    trit_t   a;
    trit_t   b;
    // Carry held over from the previous position
    trit_t   carry_in;

    // Combinational answer from the trit unit
    trit_t   result;
    trit_t   carry_out;
    logic    equal;

    // Word side presents the trits
    modport lane (output opcode, a, b, carry_in, input result, carry_out, equal);

    // Trit side computes in the same cycle
    modport unit (input opcode, a, b, carry_in, output result, carry_out, equal);

endinterface

/* verilog/trit_unit.sv */
// Single-trit ALU: negation, min, max, ternary XOR, full adder and equality
`timescale 1ns/100ps

module trit_unit
    import ternary_pkg::*;
(
    trit_lane_if.unit lane
);

    // Operands with the unused code folded to zero
    trit_t             a_n;
    trit_t             b_n;
    // Second adder input, negated for SUB
    trit_t             b_add;
    logic signed [2:0] sum_v;
    trit_t             add_sum;
    trit_t             add_carry;
    trit_t             min_t;
    trit_t             max_t;
    trit_t             xor_t;
    logic              is_add;

    function automatic trit_t fold(trit_t t);
        case (t)
            TRIT_NEG: return TRIT_NEG;
            TRIT_POS: return TRIT_POS;
            default:  return TRIT_ZERO;
        endcase
    endfunction

    function automatic logic signed [2:0] value(trit_t t);
        case (t)
            TRIT_NEG: return -3'sd1;
            TRIT_POS: return 3'sd1;
            default:  return 3'sd0;
        endcase
    endfunction

    function automatic trit_t negate(trit_t t);
        case (t)
            TRIT_NEG: return TRIT_POS;
            TRIT_POS: return TRIT_NEG;
            default:  return TRIT_ZERO;
        endcase
    endfunction

    assign a_n    = fold(lane.a);
    assign b_n    = fold(lane.b);
    assign is_add = (lane.opcode == OP_ADD) || (lane.opcode == OP_ADDI) ||
                    (lane.opcode == OP_SUB);

    // Subtraction adds the trit-wise negation of b
    assign b_add = (lane.opcode == OP_SUB) ? negate(b_n) : b_n;
    assign sum_v = value(a_n) + value(b_add) + value(lane.carry_in);

    // Full adder, raw sum -3..3 split into carry and sum trit
    always_comb begin
        case (sum_v)
            -3'sd3:  begin add_sum = TRIT_ZERO; add_carry = TRIT_NEG;  end
            -3'sd2:  begin add_sum = TRIT_POS;  add_carry = TRIT_NEG;  end
            -3'sd1:  begin add_sum = TRIT_NEG;  add_carry = TRIT_ZERO; end
            3'sd1:   begin add_sum = TRIT_POS;  add_carry = TRIT_ZERO; end
            3'sd2:   begin add_sum = TRIT_NEG;  add_carry = TRIT_POS;  end
            3'sd3:   begin add_sum = TRIT_ZERO; add_carry = TRIT_POS;  end
            default: begin add_sum = TRIT_ZERO; add_carry = TRIT_ZERO; end
        endcase
    end

    // Ternary AND and OR are min and max
    assign min_t = (value(a_n) < value(b_n)) ? a_n : b_n;
    assign max_t = (value(a_n) > value(b_n)) ? a_n : b_n;

    // XOR: zero passes the other side, opposites cancel, equal nonzero gives -1
    always_comb begin
        if (b_n == TRIT_ZERO) begin
            xor_t = a_n;
        end else if (a_n == TRIT_ZERO) begin
            xor_t = b_n;
        end else if (a_n != b_n) begin
            xor_t = TRIT_ZERO;
        end else begin
            xor_t = TRIT_NEG;
        end
    end

    always_comb begin
        case (lane.opcode)
            OP_NOT:                  lane.result = negate(a_n);
            OP_AND, OP_ANDI:         lane.result = min_t;
            OP_OR:                   lane.result = max_t;
            OP_XOR:                  lane.result = xor_t;
            OP_ADD, OP_ADDI, OP_SUB: lane.result = add_sum;
            // Everything else passes a, COMP is finished in the datapath
            default:                 lane.result = lane.a;
        endcase
    end

    // Carry only ripples for add and subtract
    assign lane.carry_out = is_add ? add_carry : TRIT_ZERO;
    assign lane.equal     = (a_n == b_n);

endmodule

/* verilog/word_datapath.sv */
// Word datapath: operand and result shift registers around the trit lane
`timescale 1ns/100ps
`include "ternary_macros.svh"

module word_datapath
    import ternary_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  load,
    input  logic                  advance,
    input  opcode_t               opcode,
    input  logic [`WORD_BITS-1:0] a,
    input  logic [`WORD_BITS-1:0] b,
    output logic [`WORD_BITS-1:0] result,
    trit_lane_if.lane             lane
);

    // Operation held for the whole word
    opcode_t               op_q;
    // Ripple carry between trit positions
    trit_t                 carry_q;
    // Still equal over all trits seen so far
    logic                  equal_q;

    // Operands shift right, lowest trit in the lane
    logic [`WORD_BITS-1:0] a_q;
    logic [`WORD_BITS-1:0] b_q;
    // Results enter at the top, word is aligned after nine steps
    logic [`WORD_BITS-1:0] res_q;

    assign lane.opcode   = op_q;
    assign lane.a        = trit_t'(a_q[`TRIT_BITS-1:0]);
    assign lane.b        = trit_t'(b_q[`TRIT_BITS-1:0]);
    assign lane.carry_in = carry_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op_q    <= OP_MV;
            carry_q <= TRIT_ZERO;
            equal_q <= 1'b1;
        end else if (load) begin
            op_q    <= opcode;
            carry_q <= TRIT_ZERO;
            equal_q <= 1'b1;
        end else if (advance) begin
            carry_q <= lane.carry_out;
            equal_q <= equal_q && lane.equal;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            a_q <= a;
            b_q <= b;
        end else if (advance) begin
            a_q   <= {{`TRIT_BITS{1'b0}}, a_q[`WORD_BITS-1:`TRIT_BITS]};
            b_q   <= {{`TRIT_BITS{1'b0}}, b_q[`WORD_BITS-1:`TRIT_BITS]};
            res_q <= {lane.result, res_q[`WORD_BITS-1:`TRIT_BITS]};
        end
    end

    // COMP gives +1 in trit 0 on a full match, zero everywhere else
    assign result = (op_q == OP_COMP) ?
                    {{(`WORD_BITS - `TRIT_BITS){1'b0}}, equal_q ? TRIT_POS : TRIT_ZERO} :
                    res_q;

endmodule
